//--- src/arcade_video_defs.svh
`ifndef ARCADE_VIDEO_DEFS_SVH
`define ARCADE_VIDEO_DEFS_SVH

// Horizontal raster, counted in half-pixels
`define H_TOTAL         10'd768
`define H_ACTIVE        10'd512
`define H_SYNC_START    10'd560
`define H_SYNC_END      10'd624

// Vertical raster, counted in lines
`define LINE_BITS       9
`define V_TOTAL         9'd264
`define V_ACTIVE_START  9'd16
`define V_ACTIVE_END    9'd240
`define V_SYNC_START    9'd248
`define V_SYNC_END      9'd252

// CPU address map
`define VRAM_BASE       16'h7400
`define VRAM_BYTES      16'd1024
`define PAL_BASE        16'h7F00
`define PAL_BYTES       16'd16
`define CTRL_ADDR       16'h7F80

// Tile fetch latency in cen12 ticks
`define PIPE_TICKS      16

`endif

//--- src/arcade_video_pkg.sv
package arcade_video_pkg;

   // Raster position, h_cnt in half-pixels
   typedef struct packed {
      logic [9:0] h_cnt;
      logic [7:0] v_cnt;
   } hv_pos_t;

   typedef struct packed {
      logic hblank;
      logic vblank;
      logic hsync_n;
      logic vsync_n;
   } hv_sync_t;

   // Control latch fields, packed in control byte order
   typedef struct packed {
      logic       flip;
      logic       bank;
      logic [1:0] pal_sel;
   } video_ctrl_t;

   typedef struct packed {
      logic       we;
      logic [9:0] addr;
      logic [7:0] data;
   } vram_wr_t;

   typedef struct packed {
      logic       we;
      logic [3:0] index;
      logic [7:0] data;
   } pal_wr_t;

   typedef struct packed {
      logic       active;
      logic [3:0] colour;
   } pix_t;

   // Palette byte layout is RRRGGGBB
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [1:0] b;
   } rgb_t;

endpackage

//--- src/cpu_video_port.sv
`timescale 1ns/10ps
`include "arcade_video_defs.svh"

module cpu_video_port (
   input  logic                          W_CLK_48M,
   input  logic                          rst_n,
   input  logic [15:0]                   cpu_addr,
   input  logic [7:0]                    cpu_data,
   input  logic                          cpu_wr_n,
   output arcade_video_pkg::vram_wr_t    vram_wr,
   output arcade_video_pkg::pal_wr_t     pal_wr,
   output arcade_video_pkg::video_ctrl_t ctrl
);

   logic       vram_hit;
   logic       pal_hit;
   logic       ctrl_hit;
   logic       vram_we_q;
   logic       pal_we_q;
   logic [9:0] addr_q;
   logic [7:0] data_q;

   // --------------------
   // Address decode
   // --------------------
   assign vram_hit = (cpu_addr >= `VRAM_BASE) &&
                     (cpu_addr < (`VRAM_BASE + `VRAM_BYTES));
   assign pal_hit  = (cpu_addr >= `PAL_BASE) &&
                     (cpu_addr < (`PAL_BASE + `PAL_BYTES));
   assign ctrl_hit = (cpu_addr == `CTRL_ADDR);

   // Address and data of the last strobe
   always_ff @(posedge W_CLK_48M) begin
      addr_q <= cpu_addr[9:0];
      data_q <= cpu_data;
   end

   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         vram_we_q <= 1'b0;
         pal_we_q  <= 1'b0;
         ctrl      <= '0;
      end else begin
         vram_we_q <= !cpu_wr_n && vram_hit;
         pal_we_q  <= !cpu_wr_n && pal_hit;
         // Bit 3 flip, bit 2 bank, bits 1:0 pal_sel
         if (!cpu_wr_n && ctrl_hit) begin
            ctrl <= arcade_video_pkg::video_ctrl_t'(cpu_data[3:0]);
         end
      end
   end

   // Both regions are aligned, so the low address bits are the offset
   assign vram_wr = '{we: vram_we_q, addr: addr_q, data: data_q};
   assign pal_wr  = '{we: pal_we_q, index: addr_q[3:0], data: data_q};

endmodule

//--- src/raster_timing.sv
`timescale 1ns/10ps
`include "arcade_video_defs.svh"

module raster_timing (
   input  logic                       W_CLK_48M,
   input  logic                       rst_n,
   output logic                       cen12,
   output arcade_video_pkg::hv_pos_t  pos,
   output arcade_video_pkg::hv_sync_t sync
);

   logic [1:0]            div;
   logic [9:0]            h_cnt;
   logic [9:0]            h_nxt;
   logic [`LINE_BITS-1:0] line_cnt;
   logic [`LINE_BITS-1:0] line_nxt;
   logic                  h_wrap;

   // --------------------
   // Clock enable
   // --------------------
   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         div <= 2'd0;
      end else begin
         div <= div + 2'd1;
      end
   end

   // One master clock in four
   assign cen12 = (div == 2'd3);

   // --------------------
   // Counters
   // --------------------
   always_comb begin
      h_wrap = (h_cnt == (`H_TOTAL - 10'd1));
      h_nxt  = h_wrap ? 10'd0 : h_cnt + 10'd1;
      line_nxt = line_cnt;
      if (h_wrap) begin
         if (line_cnt == (`V_TOTAL - 9'd1)) begin
            line_nxt = '0;
         end else begin
            line_nxt = line_cnt + 9'd1;
         end
      end
   end

   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt    <= 10'd0;
         line_cnt <= '0;
      end else if (cen12) begin
         h_cnt    <= h_nxt;
         line_cnt <= line_nxt;
      end
   end

   // Lines 256 and up alias onto 0 to 7, all inside vblank
   assign pos = '{h_cnt: h_cnt, v_cnt: line_cnt[7:0]};

   // --------------------
   // Blanking and sync
   // --------------------
   // Taken from the next count so they move together with pos
   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         sync.hblank  <= 1'b1;
         sync.vblank  <= 1'b1;
         sync.hsync_n <= 1'b1;
         sync.vsync_n <= 1'b1;
      end else if (cen12) begin
         sync.hblank  <= (h_nxt >= `H_ACTIVE);
         sync.vblank  <= (line_nxt < `V_ACTIVE_START) ||
                         (line_nxt >= `V_ACTIVE_END);
         sync.hsync_n <= !((h_nxt >= `H_SYNC_START) &&
                           (h_nxt < `H_SYNC_END));
         sync.vsync_n <= !((line_nxt >= `V_SYNC_START) &&
                           (line_nxt < `V_SYNC_END));
      end
   end

endmodule

//--- src/tile_fetch.sv
`timescale 1ns/10ps
`include "arcade_video_defs.svh"

module tile_fetch (
   input  logic                          W_CLK_48M,
   input  logic                          rst_n,
   input  logic                          cen12,
   input  arcade_video_pkg::hv_pos_t     pos,
   input  arcade_video_pkg::video_ctrl_t ctrl,
   input  arcade_video_pkg::vram_wr_t    vram_wr,
   output logic [11:0]                   bg_rom_addr,
   input  logic [15:0]                   bg_rom_do,
   output arcade_video_pkg::pix_t        pix
);

   logic [7:0] tile_ram [1024];

   logic [3:0] phase;
   logic [4:0] tile_col;
   logic [7:0] fy;
   logic [8:0] row_y;
   logic       vis;

   // Code stage, row stage and shift stage
   logic [7:0] a_code;
   logic [2:0] a_fine;
   logic       a_bank;
   logic       a_flip;
   logic [1:0] a_pal;
   logic       a_act;
   logic [7:0] b_p0;
   logic [7:0] b_p1;
   logic       b_flip;
   logic [1:0] b_pal;
   logic       b_act;
   logic [7:0] ld_p0;
   logic [7:0] ld_p1;
   logic [7:0] sh_p0;
   logic [7:0] sh_p1;
   logic [1:0] c_pal;
   logic       c_act;

   function automatic logic [7:0] rev8(input logic [7:0] d);
      logic [7:0] r;
      for (int i = 0; i < 8; i++) begin
         r[i] = d[7-i];
      end
      return r;
   endfunction

   always_ff @(posedge W_CLK_48M) begin
      if (vram_wr.we) begin
         tile_ram[vram_wr.addr] <= vram_wr.data;
      end
   end

   // --------------------
   // Flipped position
   // --------------------
   // 511 - h and 255 - v are plain inversions inside the active area
   always_comb begin
      phase    = pos.h_cnt[3:0];
      tile_col = ctrl.flip ? ~pos.h_cnt[8:4] : pos.h_cnt[8:4];
      fy       = ctrl.flip ? ~pos.v_cnt : pos.v_cnt;
      row_y    = {1'b0, fy} - `V_ACTIVE_START;
      vis      = (pos.h_cnt < `H_ACTIVE) &&
                 ({1'b0, pos.v_cnt} >= `V_ACTIVE_START) &&
                 ({1'b0, pos.v_cnt} < `V_ACTIVE_END);
   end

   // Bank, tile code, line within tile
   assign bg_rom_addr = {a_bank, a_code, a_fine};

   // Flipped tiles leave their row from the right
   assign ld_p0 = b_flip ? rev8(b_p0) : b_p0;
   assign ld_p1 = b_flip ? rev8(b_p1) : b_p1;

   // --------------------
   // Fetch pipeline
   // --------------------
   always_ff @(posedge W_CLK_48M) begin
      if (cen12) begin
         // Tile start, read the code
         if (phase == 4'd0) begin
            a_code <= tile_ram[{row_y[7:3], tile_col}];
            a_fine <= fy[2:0];
            a_bank <= ctrl.bank;
            a_flip <= ctrl.flip;
            a_pal  <= ctrl.pal_sel;
         end
         // ROM answers in the same clock
         if (phase == 4'd1) begin
            b_p0   <= bg_rom_do[7:0];
            b_p1   <= bg_rom_do[15:8];
            b_flip <= a_flip;
            b_pal  <= a_pal;
         end
         if (phase == 4'd15) begin
            sh_p0 <= ld_p0;
            sh_p1 <= ld_p1;
            c_pal <= b_pal;
         end else if (phase[0]) begin
            sh_p0 <= {sh_p0[6:0], 1'b0};
            sh_p1 <= {sh_p1[6:0], 1'b0};
         end
      end
   end

   // Load on phase 15 lands the first pixel 16 ticks after its position
   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         a_act <= 1'b0;
         b_act <= 1'b0;
         c_act <= 1'b0;
         pix   <= '0;
      end else if (cen12) begin
         if (phase == 4'd0) begin
            a_act <= vis;
         end
         if (phase == 4'd1) begin
            b_act <= a_act;
         end
         if (phase == 4'd15) begin
            c_act <= b_act;
            pix   <= '{active: b_act, colour: {b_pal, ld_p1[7], ld_p0[7]}};
         end else if (phase[0]) begin
            pix   <= '{active: c_act, colour: {c_pal, sh_p1[6], sh_p0[6]}};
         end
      end
   end

endmodule

//--- src/colour_out.sv
`timescale 1ns/10ps
`include "arcade_video_defs.svh"

module colour_out (
   input  logic                       W_CLK_48M,
   input  logic                       rst_n,
   input  logic                       cen12,
   input  arcade_video_pkg::hv_pos_t  pos,
   input  arcade_video_pkg::hv_sync_t sync,
   input  arcade_video_pkg::pal_wr_t  pal_wr,
   input  arcade_video_pkg::pix_t     pix,
   output arcade_video_pkg::rgb_t     rgb,
   output logic                       hblank,
   output logic                       vblank,
   output logic                       hsync_n,
   output logic                       vsync_n,
   output logic                       pix_strobe
);

   logic [7:0] pal_ram [16];

   arcade_video_pkg::hv_sync_t sync_dly [`PIPE_TICKS];
   arcade_video_pkg::hv_sync_t sync_out;
   logic [`PIPE_TICKS-1:0]     pix_dly;

   always_ff @(posedge W_CLK_48M) begin
      if (pal_wr.we) begin
         pal_ram[pal_wr.index] <= pal_wr.data;
      end
   end

   // --------------------
   // Sync delay line
   // --------------------
   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PIPE_TICKS; i++) begin
            sync_dly[i] <= '{hblank: 1'b1, vblank: 1'b1, hsync_n: 1'b1, vsync_n: 1'b1};
         end
         pix_dly <= '0;
      end else if (cen12) begin
         sync_dly[0] <= sync;
         for (int i = 1; i < `PIPE_TICKS; i++) begin
            sync_dly[i] <= sync_dly[i-1];
         end
         pix_dly <= {pix_dly[`PIPE_TICKS-2:0], pos.h_cnt[0]};
      end
   end

   assign sync_out = sync_dly[`PIPE_TICKS-1];

   // Output register, one master clock after the pipeline
   always_ff @(posedge W_CLK_48M or negedge rst_n) begin
      if (!rst_n) begin
         rgb        <= '0;
         hblank     <= 1'b1;
         vblank     <= 1'b1;
         hsync_n    <= 1'b1;
         vsync_n    <= 1'b1;
         pix_strobe <= 1'b0;
      end else begin
         if (pix.active && !sync_out.hblank && !sync_out.vblank) begin
            rgb <= arcade_video_pkg::rgb_t'(pal_ram[pix.colour]);
         end else begin
            rgb <= '0;
         end
         hblank     <= sync_out.hblank;
         vblank     <= sync_out.vblank;
         hsync_n    <= sync_out.hsync_n;
         vsync_n    <= sync_out.vsync_n;
         pix_strobe <= pix_dly[`PIPE_TICKS-1];
      end
   end

endmodule

//--- src/arcade_video_top.sv
`timescale 1ns/10ps

module arcade_video_top (
   input  logic                   W_CLK_48M,
   input  logic                   rst_n,
   input  logic [15:0]            cpu_addr,
   input  logic [7:0]             cpu_data,
   input  logic                   cpu_wr_n,
   output logic [11:0]            bg_rom_addr,
   input  logic [15:0]            bg_rom_do,
   output arcade_video_pkg::rgb_t rgb,
   output logic                   hblank,
   output logic                   vblank,
   output logic                   hsync_n,
   output logic                   vsync_n,
   output logic                   pix
);

   logic                          cen12;
   arcade_video_pkg::hv_pos_t     pos;
   arcade_video_pkg::hv_sync_t    sync;
   arcade_video_pkg::video_ctrl_t ctrl;
   arcade_video_pkg::vram_wr_t    vram_wr;
   arcade_video_pkg::pal_wr_t     pal_wr;
   arcade_video_pkg::pix_t        tile_pix;

   // --------------------
   // CPU side
   // --------------------
   cpu_video_port u_port (
      .W_CLK_48M (W_CLK_48M),
      .rst_n     (rst_n),
      .cpu_addr  (cpu_addr),
      .cpu_data  (cpu_data),
      .cpu_wr_n  (cpu_wr_n),
      .vram_wr   (vram_wr),
      .pal_wr    (pal_wr),
      .ctrl      (ctrl)
   );

   raster_timing u_timing (
      .W_CLK_48M (W_CLK_48M),
      .rst_n     (rst_n),
      .cen12     (cen12),
      .pos       (pos),
      .sync      (sync)
   );

   // --------------------
   // Background and colour
   // --------------------
   tile_fetch u_fetch (
      .W_CLK_48M   (W_CLK_48M),
      .rst_n       (rst_n),
      .cen12       (cen12),
      .pos         (pos),
      .ctrl        (ctrl),
      .vram_wr     (vram_wr),
      .bg_rom_addr (bg_rom_addr),
      .bg_rom_do   (bg_rom_do),
      .pix         (tile_pix)
   );

   colour_out u_colour (
      .W_CLK_48M  (W_CLK_48M),
      .rst_n      (rst_n),
      .cen12      (cen12),
      .pos        (pos),
      .sync       (sync),
      .pal_wr     (pal_wr),
      .pix        (tile_pix),
      .rgb        (rgb),
      .hblank     (hblank),
      .vblank     (vblank),
      .hsync_n    (hsync_n),
      .vsync_n    (vsync_n),
      .pix_strobe (pix)
   );

endmodule

//--- testbench/tb_arcade_video.sv
`timescale 1ns/10ps

module tb_arcade_video;

   localparam int FRAME_CLKS = 768 * 264 * 4;
   localparam int CMD_MAX    = 128;
   localparam int PIX_MAX    = 256 * 224;

   logic                   W_CLK_48M;
   logic                   rst_n;
   logic [15:0]            cpu_addr;
   logic [7:0]             cpu_data;
   logic                   cpu_wr_n;
   logic [11:0]            bg_rom_addr;
   logic [15:0]            bg_rom_do;
   arcade_video_pkg::rgb_t rgb;
   logic                   hblank;
   logic                   vblank;
   logic                   hsync_n;
   logic                   vsync_n;
   logic                   pix;

   logic [31:0] cmd_mem [CMD_MAX];
   logic [7:0]  exp_rgb [PIX_MAX];
   logic        exp_valid [PIX_MAX];
   int          probe_q [$];
   int          err_cnt;
   int          test_cnt;
   int          fail_tests;
   logic        timeout_hit;

   arcade_video_top UUT (
      .W_CLK_48M   (W_CLK_48M),
      .rst_n       (rst_n),
      .cpu_addr    (cpu_addr),
      .cpu_data    (cpu_data),
      .cpu_wr_n    (cpu_wr_n),
      .bg_rom_addr (bg_rom_addr),
      .bg_rom_do   (bg_rom_do),
      .rgb         (rgb),
      .hblank      (hblank),
      .vblank      (vblank),
      .hsync_n     (hsync_n),
      .vsync_n     (vsync_n),
      .pix         (pix)
   );

   // Pattern ROM with the high byte taken from the top address bits
   assign bg_rom_do = {bg_rom_addr[11:4], bg_rom_addr[7:0] ^ 8'hA5};

   initial begin
      W_CLK_48M = 1'b0;
      forever begin
         #20 W_CLK_48M = ~W_CLK_48M;
      end
   end

   // --------------------
   // Helpers
   // --------------------
   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("Test %0d %s: ok", test_cnt, name);
      end else begin
         fail_tests++;
         $display("Test %0d %s: failed", test_cnt, name);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      timeout_hit = 1'b1;
      err_cnt++;
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge W_CLK_48M);
      #2;
      cpu_addr = addr;
      cpu_data = data;
      cpu_wr_n = 1'b0;
      @(posedge W_CLK_48M);
      #2;
      cpu_wr_n = 1'b1;
   endtask

   // Random data to addresses outside the three regions
   task automatic unmapped_writes();
      logic [15:0] addrs [5];
      logic [31:0] r;
      addrs = '{16'h0000, 16'h73FF, 16'h7800, 16'h7F10, 16'h7F81};
      for (int i = 0; i < 5; i++) begin
         r = $urandom;
         cpu_write(addrs[i], r[7:0]);
      end
   endtask

   // --------------------
   // Raster checks
   // --------------------
   task automatic sweep_frame();
      int   n;
      int   frame_clks;
      int   hs_falls;
      int   act_lines;
      int   pix_rises;
      int   errs;
      logic started;
      logic done;
      logic prev_hs;
      logic prev_vs;
      logic prev_hb;
      logic prev_pix;
      errs = err_cnt;
      n = 0;
      frame_clks = 0;
      hs_falls = 0;
      act_lines = 0;
      pix_rises = 0;
      started = 1'b0;
      done = 1'b0;
      @(negedge W_CLK_48M);
      prev_hs = hsync_n;
      prev_vs = vsync_n;
      prev_hb = hblank;
      prev_pix = pix;
      while (!done && !timeout_hit) begin
         @(negedge W_CLK_48M);
         n++;
         if (started) begin
            frame_clks++;
         end
         if (prev_vs && !vsync_n) begin
            if (started) begin
               done = 1'b1;
            end else begin
               started = 1'b1;
            end
         end
         if (started && prev_hs && !hsync_n) begin
            hs_falls++;
         end
         if (started && !vblank && prev_hb && !hblank) begin
            pix_rises = 0;
         end
         if (started && !vblank && !hblank && !prev_pix && pix) begin
            pix_rises++;
         end
         if (started && !vblank && !prev_hb && hblank) begin
            compare(pix_rises, 256, "pix edges in an active line");
            act_lines++;
         end
         if (n > 3 * FRAME_CLKS) begin
            report_timeout("no two vsync pulses seen during the raster sweep");
         end
         prev_hs = hsync_n;
         prev_vs = vsync_n;
         prev_hb = hblank;
         prev_pix = pix;
      end
      compare(hs_falls, 264, "hsync pulses per frame");
      compare(frame_clks, FRAME_CLKS, "master clocks from one vsync pulse to the next");
      compare(act_lines, 224, "active lines per frame");
      finish_test("raster timing", errs);
   endtask

   // Probes are sampled at the pix rising edge over one active frame
   task automatic scan_probes();
      int   n;
      int   line;
      int   xcnt;
      int   idx;
      int   hits;
      int   errs;
      logic started;
      logic done;
      logic blank_ok;
      logic prev_vb;
      logic prev_hb;
      logic prev_pix;
      errs = err_cnt;
      n = 0;
      line = 0;
      xcnt = 0;
      hits = 0;
      started = 1'b0;
      done = 1'b0;
      blank_ok = 1'b1;
      @(negedge W_CLK_48M);
      prev_vb = vblank;
      prev_hb = hblank;
      prev_pix = pix;
      while (!done && !timeout_hit) begin
         @(negedge W_CLK_48M);
         n++;
         if (prev_vb && !vblank) begin
            started = 1'b1;
            line = 0;
            xcnt = 0;
         end else if (started && !prev_vb && vblank) begin
            done = 1'b1;
         end else if (prev_hb && !hblank) begin
            line++;
            xcnt = 0;
         end
         if (started && !vblank && !hblank && !prev_pix && pix) begin
            idx = line * 256 + xcnt;
            if (xcnt < 256 && line < 224 && exp_valid[idx]) begin
               compare(32'(rgb), 32'(exp_rgb[idx]), $sformatf("rgb at (%0d, %0d)", xcnt, line));
               hits++;
            end
            xcnt++;
         end
         if ((hblank || vblank) && blank_ok && rgb !== 8'h00) begin
            compare(32'(rgb), 32'h0, "rgb while blanked");
            blank_ok = 1'b0;
         end
         if (n > 3 * FRAME_CLKS) begin
            report_timeout("no complete active frame seen while scanning probes");
         end
         prev_vb = vblank;
         prev_hb = hblank;
         prev_pix = pix;
      end
      if (hits != probe_q.size()) begin
         $display("Only %0d of %0d probe points were reached", hits, probe_q.size());
         err_cnt++;
      end
      foreach (probe_q[i]) begin
         exp_valid[probe_q[i]] = 1'b0;
      end
      probe_q.delete();
      finish_test("probed pixels", errs);
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      logic [31:0] w;
      logic [31:0] seed;
      int          pc;
      int          idx;
      int          errs;
      rst_n = 1'b0;
      cpu_addr = 16'h0;
      cpu_data = 8'h0;
      cpu_wr_n = 1'b1;
      err_cnt = 0;
      test_cnt = 0;
      fail_tests = 0;
      timeout_hit = 1'b0;
      seed = $urandom(66);
      for (int i = 0; i < PIX_MAX; i++) begin
         exp_valid[i] = 1'b0;
      end
      $readmemh("testbench/video_stimulus.txt", cmd_mem);
      repeat (2) @(posedge W_CLK_48M);
      #2;
      rst_n = 1'b1;

      errs = err_cnt;
      @(negedge W_CLK_48M);
      compare(32'(rgb), 32'h0, "rgb after reset");
      compare(32'(hblank), 32'h1, "hblank after reset");
      compare(32'(vblank), 32'h1, "vblank after reset");
      compare(32'(hsync_n), 32'h1, "hsync_n after reset");
      compare(32'(vsync_n), 32'h1, "vsync_n after reset");
      finish_test("reset levels", errs);

      sweep_frame();

      pc = 0;
      while (pc < CMD_MAX && !timeout_hit && cmd_mem[pc][31:28] != 4'h0) begin
         w = cmd_mem[pc];
         case (w[31:28])
            4'h1: cpu_write(w[23:8], w[7:0]);
            4'h2: begin
               idx = int'(w[15:8]) * 256 + int'(w[23:16]);
               exp_rgb[idx] = w[7:0];
               exp_valid[idx] = 1'b1;
               probe_q.push_back(idx);
            end
            4'h3: scan_probes();
            4'h4: unmapped_writes();
            default: begin
               $display("Unknown command word %h in the stimulus file", w);
               err_cnt++;
            end
         endcase
         pc++;
      end

      $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
      if (timeout_hit || err_cnt != 0) begin
         $display("TEST FAIL");
      end else begin
         $display("TEST PASS");
      end
      $finish;
   end

endmodule

//--- testbench/video_stimulus.txt
// op 1: 1 0 AAAA DD   CPU write of DD to address AAAA
// op 2: 2 0 XX YY RR  probe pixel XX on visible line YY, expected rgb RR
// op 3: scan one frame for the probes, op 4: unmapped writes, op 0: end
107F000F
107F011E
107F022D
107F033C
107F044B
107F055A
107F0669
107F0778
107F0887
107F0996
107F0AA5
107F0BB4
107F0CC3
107F0DD2
107F0EE1
107F0FF0
10740012
1074213C
10777FC7
2005031E
200B0C2D
200D093C
20FCDE1E
30000000
// Flip set
107F8008
20FADC1E
20F4D32D
20F2D63C
2003011E
30000000
// Bank 1, pal_sel 2
107F8006
20050396
200B0CA5
200D09B4
20FCDE96
30000000
40000000
20050396
200B0CA5
200D09B4
20FCDE96
30000000
00000000

//--- build.f
+incdir+src
src/arcade_video_pkg.sv
src/cpu_video_port.sv
src/raster_timing.sv
src/tile_fetch.sv
src/colour_out.sv
src/arcade_video_top.sv
testbench/tb_arcade_video.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -f build.f \
		--top-module tb_arcade_video -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
